/* common/rvExecPkg.sv */
`include "rvExec_cfg.svh"

package rvExecPkg;

    // Register values, immediates, PCs and results
    typedef logic [`RV_XLEN-1:0] dataWordT;

    // Register index
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] regAddrT;

    typedef logic [6:0] opcodeT;        // Major opcode field
    typedef logic [2:0] funct3T;        // Minor operation field

    // Raw instruction word as fetched
    typedef logic [31:0] instrWordT;

endpackage

/* common/rvExec_cfg.svh */
`ifndef RVEXEC_CFG_SVH
`define RVEXEC_CFG_SVH

`define RV_XLEN     32              // Register width in bits
`define RV_NUM_REGS 32              // Architectural registers incl. x0

// RV32I major opcodes handled by the slice
`define OPC_LUI     7'b0110111      // U format
`define OPC_AUIPC   7'b0010111      // U format
`define OPC_JAL     7'b1101111      // J format
`define OPC_JALR    7'b1100111      // I format
`define OPC_BRANCH  7'b1100011      // B format
`define OPC_OP      7'b0110011      // Register-register ALU
`define OPC_OPIMM   7'b0010011      // Register-immediate ALU
`define OPC_STORE   7'b0100011      // S format, immediate decode only

// Conditional branch funct3 codes
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100          // Signed
`define F3_BGE      3'b101          // Signed
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`endif

/* execute/aluUnit.sv */
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module aluUnit (
    input  rvExecPkg::opcodeT   opcode,
    input  rvExecPkg::funct3T   funct3,         // ALU operation
    input  logic                altOp,          // SUB or arithmetic shift
    input  rvExecPkg::dataWordT immediate,
    input  rvExecPkg::dataWordT rData1,
    input  rvExecPkg::dataWordT rData2,
    output rvExecPkg::dataWordT aluData
);

    logic                isOp;
    logic                isOpImm;
    rvExecPkg::dataWordT opB;                   // Second operand
    logic [4:0]          shAmt;
    rvExecPkg::dataWordT result;

    assign isOp    = (opcode == `OPC_OP);
    assign isOpImm = (opcode == `OPC_OPIMM);
    assign opB     = isOpImm ? immediate : rData2;
    assign shAmt   = opB[4:0];                  // Low five bits only

    always_comb begin
        case (funct3)
            3'b000: begin                       // ADD/ADDI/SUB
                if (isOp && altOp) begin
                    result = rData1 - opB;      // No SUBI in RV32I
                end else begin
                    result = rData1 + opB;
                end
            end
            3'b001: result = rData1 << shAmt;   // SLL
            3'b010: result = {31'b0, $signed(rData1) < $signed(opB)};   // SLT
            3'b011: result = {31'b0, rData1 < opB};                     // SLTU
            3'b100: result = rData1 ^ opB;      // XOR
            3'b101: begin
                if (altOp) begin
                    result = $signed(rData1) >>> shAmt;     // SRA
                end else begin
                    result = rData1 >> shAmt;   // SRL
                end
            end
            3'b110: result = rData1 | opB;      // OR
            default: result = rData1 & opB;     // AND
        endcase
    end

    // Zero outside the two ALU groups
    assign aluData = (isOp || isOpImm) ? result : '0;

endmodule

/* execute/branchUnit.sv */
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module branchUnit (
    input  rvExecPkg::opcodeT   opcode,
    input  rvExecPkg::funct3T   funct3,         // Branch condition
    input  rvExecPkg::dataWordT immediate,
    input  rvExecPkg::dataWordT pc,             // PC of this instruction
    input  rvExecPkg::dataWordT rData1,         // Compare operand and JALR base
    input  rvExecPkg::dataWordT rData2,         // Compare operand
    output rvExecPkg::dataWordT branchTarget,   // Redirect PC
    output logic                branchTaken,
    output rvExecPkg::dataWordT linkData,       // rd value for U and jump types
    output logic                branchFlush     // Kill the slot behind
);

    logic                isEq;
    logic                isLt;                  // Signed
    logic                isLtu;                 // Unsigned
    logic                condTrue;
    rvExecPkg::dataWordT pcRel;                 // PC plus immediate
    rvExecPkg::dataWordT regRel;                // rs1 plus immediate
    rvExecPkg::dataWordT pcNext;                // Return address

    assign isEq   = (rData1 == rData2);
    assign isLt   = ($signed(rData1) < $signed(rData2));
    assign isLtu  = (rData1 < rData2);
    assign pcRel  = pc + immediate;
    assign regRel = rData1 + immediate;
    assign pcNext = pc + 32'd4;

    always_comb begin
        case (funct3)
            `F3_BEQ:  condTrue = isEq;
            `F3_BNE:  condTrue = ~isEq;
            `F3_BLT:  condTrue = isLt;
            `F3_BGE:  condTrue = ~isLt;
            `F3_BLTU: condTrue = isLtu;
            `F3_BGEU: condTrue = ~isLtu;
            default:  condTrue = 1'b0;          // 010 and 011 never taken
        endcase
    end

    always_comb begin
        branchTaken  = 1'b0;
        branchTarget = '0;
        linkData     = '0;
        case (opcode)
            `OPC_LUI:   linkData = immediate;
            `OPC_AUIPC: linkData = pcRel;
            `OPC_JAL: begin
                branchTaken  = 1'b1;
                branchTarget = pcRel;
                linkData     = pcNext;
            end
            `OPC_JALR: begin
                branchTaken  = 1'b1;
                branchTarget = {regRel[31:1], 1'b0};    // LSB cleared
                linkData     = pcNext;
            end
            `OPC_BRANCH: begin
                branchTaken  = condTrue;
                branchTarget = condTrue ? pcRel : '0;   // Zero when not taken
            end
            default: ;                          // Not a control transfer
        endcase
    end

    assign branchFlush = branchTaken;           // Every taken transfer flushes

endmodule

/* flist.f */
+incdir+common
common/rvExecPkg.sv
logic/instrDecode.sv
logic/regFile.sv
execute/branchUnit.sv
execute/aluUnit.sv
logic/writeback.sv
logic/rvExecTop.sv
verif/tbRvExec.sv

/* logic/instrDecode.sv */
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module instrDecode (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,    // Strobe from the stage ahead
    input  rvExecPkg::instrWordT instr,
    input  rvExecPkg::dataWordT  pc,
    input  logic                 squash,        // Taken transfer in execute
    output logic                 exValid,       // Execute slot occupied
    output rvExecPkg::opcodeT    opcode,
    output rvExecPkg::funct3T    funct3,
    output logic                 altOp,         // SUB and SRA/SRAI marker
    output rvExecPkg::regAddrT   rd,
    output rvExecPkg::regAddrT   rs1,
    output rvExecPkg::regAddrT   rs2,
    output rvExecPkg::dataWordT  immediate,     // Sign-extended
    output rvExecPkg::dataWordT  exPc
);

    rvExecPkg::instrWordT instrQ;               // Decode register
    rvExecPkg::dataWordT  pcQ;                  // PC of the instruction in execute
    logic                 accept;

    assign accept = instrValid & ~squash;       // Slot behind a taken jump is dropped

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= accept;                  // Clears on idle or squash
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instrQ <= instr;
            pcQ    <= pc;
        end
    end

    // Fixed field positions of RV32I
    assign opcode = instrQ[6:0];
    assign rd     = instrQ[11:7];
    assign funct3 = instrQ[14:12];
    assign rs1    = instrQ[19:15];
    assign rs2    = instrQ[24:20];
    assign altOp  = instrQ[30];
    assign exPc   = pcQ;

    always_comb begin
        case (opcode)
            `OPC_LUI, `OPC_AUIPC:                                       // U format
                immediate = {instrQ[31:12], 12'b0};
            `OPC_JAL:                                                   // J format
                immediate = {{12{instrQ[31]}}, instrQ[19:12], instrQ[20],
                             instrQ[30:21], 1'b0};
            `OPC_BRANCH:                                                // B format
                immediate = {{20{instrQ[31]}}, instrQ[7], instrQ[30:25],
                             instrQ[11:8], 1'b0};
            `OPC_STORE:                                                 // S format
                immediate = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};
            default:                                                    // I format
                immediate = {{20{instrQ[31]}}, instrQ[31:20]};
        endcase
    end

    // A squash comes only from a valid transfer and empties the next slot
    squashDropsSlot: assert property (
        @(posedge clk) disable iff (!arstN)
        squash |-> exValid ##1 !exValid
    ) else $error("instrDecode: squash without a valid slot or exValid rose after it");

endmodule

/* logic/regFile.sv */
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module regFile (
    input  logic                clk,
    input  logic                arstN,
    input  rvExecPkg::regAddrT  rs1,
    input  rvExecPkg::regAddrT  rs2,
    output rvExecPkg::dataWordT rData1,         // Asynchronous read
    output rvExecPkg::dataWordT rData2,
    input  logic                wrEn,
    input  rvExecPkg::regAddrT  wrAddr,
    input  rvExecPkg::dataWordT wrData
);

    rvExecPkg::dataWordT regs [`RV_NUM_REGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin  // x0 never written
            regs[wrAddr] <= wrData;
        end
    end

    // x0 stays zero from reset
    assign rData1 = regs[rs1];
    assign rData2 = regs[rs2];

    x0ReadsZero1: assert property (
        @(posedge clk) disable iff (!arstN)
        (rs1 == '0) |-> (rData1 == '0)
    ) else $error("regFile: x0 read nonzero on port 1");

    x0ReadsZero2: assert property (
        @(posedge clk) disable iff (!arstN)
        (rs2 == '0) |-> (rData2 == '0)
    ) else $error("regFile: x0 read nonzero on port 2");

endmodule

/* logic/rvExecTop.sv */
`timescale 1ns/100ps

module rvExecTop (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  rvExecPkg::instrWordT instr,
    input  rvExecPkg::dataWordT  pc,
    output logic                 resValid,
    output logic                 pcSrc,         // Redirect request
    output rvExecPkg::dataWordT  pcBranch,
    output logic                 flush,
    output logic                 wbEn,
    output rvExecPkg::regAddrT   wbAddr,
    output rvExecPkg::dataWordT  wbData
);

    // Decode register outputs
    logic                exValid;
    rvExecPkg::opcodeT   opcode;
    rvExecPkg::funct3T   funct3;
    logic                altOp;
    rvExecPkg::regAddrT  rd;
    rvExecPkg::regAddrT  rs1;
    rvExecPkg::regAddrT  rs2;
    rvExecPkg::dataWordT immediate;
    rvExecPkg::dataWordT exPc;

    rvExecPkg::dataWordT rData1;                // Operands
    rvExecPkg::dataWordT rData2;

    rvExecPkg::dataWordT branchTarget;
    logic                branchTaken;
    logic                branchFlush;
    rvExecPkg::dataWordT linkData;
    rvExecPkg::dataWordT aluData;

    logic                squash;
    logic                wrEn;                  // Write-through port
    rvExecPkg::regAddrT  wrAddr;
    rvExecPkg::dataWordT wrData;

    instrDecode i_decode (
        .clk, .arstN, .instrValid, .instr, .pc, .squash,
        .exValid, .opcode, .funct3, .altOp, .rd, .rs1, .rs2, .immediate, .exPc
    );

    regFile i_regFile (
        .clk, .arstN, .rs1, .rs2, .rData1, .rData2, .wrEn, .wrAddr, .wrData
    );

    branchUnit i_branch (
        .opcode, .funct3, .immediate, .pc(exPc), .rData1, .rData2,
        .branchTarget, .branchTaken, .linkData, .branchFlush
    );

    aluUnit i_alu (
        .opcode, .funct3, .altOp, .immediate, .rData1, .rData2, .aluData
    );

    writeback i_writeback (
        .clk, .arstN, .exValid, .opcode, .rd,
        .branchTarget, .branchTaken, .branchFlush, .linkData, .aluData,
        .squash, .wrEn, .wrAddr, .wrData,
        .resValid, .pcSrc, .pcBranch, .flush, .wbEn, .wbAddr, .wbData
    );

endmodule

/* logic/writeback.sv */
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module writeback (
    input  logic                clk,
    input  logic                arstN,
    input  logic                exValid,
    input  rvExecPkg::opcodeT   opcode,
    input  rvExecPkg::regAddrT  rd,
    input  rvExecPkg::dataWordT branchTarget,
    input  logic                branchTaken,
    input  logic                branchFlush,
    input  rvExecPkg::dataWordT linkData,
    input  rvExecPkg::dataWordT aluData,
    output logic                squash,         // Back to decode
    output logic                wrEn,           // Register file write port
    output rvExecPkg::regAddrT  wrAddr,
    output rvExecPkg::dataWordT wrData,
    output logic                resValid,       // One pulse per accepted instr
    output logic                pcSrc,
    output rvExecPkg::dataWordT pcBranch,
    output logic                flush,
    output logic                wbEn,
    output rvExecPkg::regAddrT  wbAddr,
    output rvExecPkg::dataWordT wbData
);

    logic isLink;                               // LUI, AUIPC, JAL, JALR
    logic isAlu;                                // OP, OP-IMM

    assign isLink = (opcode == `OPC_LUI) || (opcode == `OPC_AUIPC) ||
                    (opcode == `OPC_JAL) || (opcode == `OPC_JALR);
    assign isAlu  = (opcode == `OPC_OP) || (opcode == `OPC_OPIMM);

    assign squash = exValid & branchFlush;
    assign wrEn   = exValid & (isLink | isAlu) & (rd != '0);
    assign wrAddr = rd;
    assign wrData = isLink ? linkData : (isAlu ? aluData : '0);   // No-op reports zero

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
            pcSrc    <= 1'b0;
            flush    <= 1'b0;
            wbEn     <= 1'b0;
            pcBranch <= '0;
            wbAddr   <= '0;
            wbData   <= '0;
        end else begin
            resValid <= exValid;
            pcSrc    <= exValid & branchTaken;
            flush    <= squash;
            wbEn     <= wrEn;
            if (exValid) begin                  // Data holds while idle
                pcBranch <= branchTaken ? branchTarget : '0;
                wbAddr   <= rd;
                wbData   <= wrData;
            end
        end
    end

    redirectFlushes: assert property (@(posedge clk) disable iff (!arstN) pcSrc |-> flush)
        else $error("writeback: pcSrc without flush");

    writeNotX0: assert property (@(posedge clk) disable iff (!arstN) wbEn |-> (wbAddr != '0))
        else $error("writeback: write reported to x0");

endmodule

/* verif/tbRvExec.sv */
`timescale 1ns/100ps
`include "rvExec_cfg.svh"

module tbRvExec;

    logic                 clk;
    logic                 arstN;
    logic                 instrValid;
    rvExecPkg::instrWordT instr;
    rvExecPkg::dataWordT  pc;
    logic                 resValid;
    logic                 pcSrc;
    rvExecPkg::dataWordT  pcBranch;
    logic                 flush;
    logic                 wbEn;
    rvExecPkg::regAddrT   wbAddr;
    rvExecPkg::dataWordT  wbData;

    integer              seed = 32'ha37defe9;
    int                  cycleCnt = 0;          // Rising edges seen
    int                  errCount = 0;
    int                  testErrBase = 0;
    int                  testsDone = 0;
    int                  resultCnt = 0;
    int                  droppedCnt = 0;
    rvExecPkg::dataWordT modelRegs [32];
    logic                lastTaken;             // Accepted transfer now in execute
    rvExecPkg::dataWordT pcNow;

    // Expected results, oldest first
    int                  qDue [$];              // Cycle in which resValid is due
    logic                qTaken [$];
    rvExecPkg::dataWordT qTarget [$];
    logic                qWbEn [$];
    rvExecPkg::regAddrT  qAddr [$];
    rvExecPkg::dataWordT qData [$];

    rvExecTop i_dut (
        .clk, .arstN, .instrValid, .instr, .pc,
        .resValid, .pcSrc, .pcBranch, .flush, .wbEn, .wbAddr, .wbData
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                       // 4 ns period

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    task automatic checkWord(input string what, input rvExecPkg::dataWordT got,
                             input rvExecPkg::dataWordT exp);
        if (got !== exp) begin
            errCount++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkAddr(input string what, input rvExecPkg::regAddrT got,
                             input rvExecPkg::regAddrT exp);
        if (got !== exp) begin
            errCount++;
            $display("FAILED at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errCount++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkQuiet(input string tag);    // No result in flight
        checkBit({tag, " resValid"}, resValid, 1'b0);
        checkBit({tag, " pcSrc"}, pcSrc, 1'b0);
        checkBit({tag, " flush"}, flush, 1'b0);
        checkBit({tag, " wbEn"}, wbEn, 1'b0);
    endtask

    task automatic popExpected();
        void'(qDue.pop_front());
        void'(qTaken.pop_front());
        void'(qTarget.pop_front());
        void'(qWbEn.pop_front());
        void'(qAddr.pop_front());
        void'(qData.pop_front());
    endtask

    task automatic checkCycle();
        while (qDue.size() > 0 && qDue[0] < cycleCnt) begin    // Overdue entries
            errCount++;
            $display("Missing result: no resValid for the instruction due in cycle %0d",
                     qDue[0]);
            popExpected();
        end
        if (resValid !== 1'b1) begin
            checkQuiet("idle");
        end else if (qDue.size() == 0 || qDue[0] != cycleCnt) begin
            errCount++;
            $display("Unexpected result: resValid in cycle %0d with nothing due", cycleCnt);
        end else begin
            resultCnt++;
            checkBit("pcSrc", pcSrc, qTaken[0]);
            checkBit("flush", flush, qTaken[0]);   // Every taken transfer flushes
            checkWord("pcBranch", pcBranch, qTarget[0]);
            checkBit("wbEn", wbEn, qWbEn[0]);
            checkAddr("wbAddr", wbAddr, qAddr[0]);
            checkWord("wbData", wbData, qData[0]);
            popExpected();
        end
    endtask

    always @(negedge clk) begin
        if (arstN === 1'b1) checkCycle();       // Outputs settled mid-cycle
    end

    // Reference model of one accepted instruction
    task automatic modelExec(input rvExecPkg::instrWordT ins, input rvExecPkg::dataWordT pcv);
        rvExecPkg::opcodeT   opc;
        rvExecPkg::funct3T   f3;
        rvExecPkg::regAddrT  rdIdx;
        rvExecPkg::dataWordT a;
        rvExecPkg::dataWordT b;
        rvExecPkg::dataWordT immI;
        rvExecPkg::dataWordT immU;
        rvExecPkg::dataWordT immB;
        rvExecPkg::dataWordT immJ;
        rvExecPkg::dataWordT res;
        rvExecPkg::dataWordT target;
        logic                taken;
        logic                writes;
        opc    = ins[6:0];
        f3     = ins[14:12];
        rdIdx  = ins[11:7];
        a      = modelRegs[ins[19:15]];
        b      = modelRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immU   = {ins[31:12], 12'h000};
        immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        res    = '0;
        target = '0;
        taken  = 1'b0;
        writes = 1'b0;
        if (opc == `OPC_LUI || opc == `OPC_AUIPC) begin
            res    = (opc == `OPC_LUI) ? immU : pcv + immU;
            writes = 1'b1;
        end else if (opc == `OPC_JAL || opc == `OPC_JALR) begin
            taken  = 1'b1;
            target = (opc == `OPC_JAL) ? pcv + immJ : (a + immI) & ~32'h1;
            res    = pcv + 32'd4;               // Return address
            writes = 1'b1;
        end else if (opc == `OPC_BRANCH) begin
            case (f3)
                `F3_BEQ:  taken = (a == b);
                `F3_BNE:  taken = (a != b);
                `F3_BLT:  taken = ($signed(a) < $signed(b));
                `F3_BGE:  taken = ($signed(a) >= $signed(b));
                `F3_BLTU: taken = (a < b);
                `F3_BGEU: taken = (a >= b);
                default:  taken = 1'b0;
            endcase
            if (taken) target = pcv + immB;
        end else if (opc == `OPC_OP || opc == `OPC_OPIMM) begin
            writes = 1'b1;
            if (opc == `OPC_OPIMM) b = immI;
            case (f3)
                3'd0: res = (opc == `OPC_OP && ins[30]) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    if (ins[30]) res = $signed(a) >>> b[4:0];
                    else res = a >> b[4:0];
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
        qDue.push_back(cycleCnt + 2);           // Sampled next edge, registered one later
        qTaken.push_back(taken);
        qTarget.push_back(target);
        qWbEn.push_back(writes && rdIdx != '0);
        qAddr.push_back(rdIdx);
        qData.push_back(res);
        if (writes && rdIdx != '0) modelRegs[rdIdx] = res;
        lastTaken = taken;
    endtask

    task automatic presentInstr(input rvExecPkg::instrWordT ins);
        @(posedge clk);
        #1;
        instrValid = 1'b1;
        instr      = ins;
        pc         = pcNow;
        if (lastTaken) begin                    // Slot behind a taken transfer
            lastTaken = 1'b0;
            droppedCnt++;
        end else begin
            modelExec(ins, pcNow);
        end
        pcNow = pcNow + 32'd4;
    endtask

    task automatic driveIdle();
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        instr      = $random(seed);             // Junk while idle
        lastTaken  = 1'b0;
    endtask

    function automatic rvExecPkg::regAddrT pickReg();
        return rvExecPkg::regAddrT'({$random(seed)} % 6);   // x0..x5 only
    endfunction

    function automatic rvExecPkg::dataWordT pickValue();
        case ({$random(seed)} % 5)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    // Kind 0 LUI, 1 AUIPC, 2 OP, 3 OP-IMM, 4 JAL, 5 JALR, 6 branch, 7 unhandled
    function automatic rvExecPkg::instrWordT makeInstr(input int kind);
        rvExecPkg::instrWordT ins;
        ins        = $random(seed);
        ins[11:7]  = pickReg();
        ins[19:15] = pickReg();
        ins[24:20] = pickReg();
        case (kind)
            0: ins[6:0] = `OPC_LUI;
            1: ins[6:0] = `OPC_AUIPC;
            2: begin
                ins[6:0]   = `OPC_OP;
                ins[31:25] = {1'b0, ins[30], 5'b00000};
            end
            3: ins[6:0] = `OPC_OPIMM;
            4: ins[6:0] = `OPC_JAL;
            5: ins[6:0] = `OPC_JALR;
            6: ins[6:0] = `OPC_BRANCH;
            default: begin
                case ({$random(seed)} % 3)
                    0: ins[6:0] = 7'b0000011;   // LOAD
                    1: ins[6:0] = `OPC_STORE;
                    default: ins[6:0] = 7'b1110011;     // SYSTEM
                endcase
            end
        endcase
        return ins;
    endfunction

    task automatic loadReg(input rvExecPkg::regAddrT rdIdx, input rvExecPkg::dataWordT value);
        rvExecPkg::dataWordT rounded;
        rounded = value + 32'h800;              // ADDI immediate is signed
        if (lastTaken) driveIdle();
        presentInstr({rounded[31:12], rdIdx, `OPC_LUI});
        presentInstr({value[11:0], rdIdx, 3'b000, rdIdx, `OPC_OPIMM});
    endtask

    task automatic finishTest(input string name);
        int waited;
        driveIdle();
        waited = 0;
        while (qDue.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (qDue.size() > 0) begin
            $display("Timeout: results of test %s still outstanding after 20 cycles", name);
            $display("Simulation failed");
            $finish;
        end
        @(negedge clk);
        #1;                                     // Let the monitor finish this cycle
        testsDone++;
        $display("Test %-9s finished with %0d errors", name, errCount - testErrBase);
        testErrBase = errCount;
    endtask

    initial begin
        rvExecPkg::instrWordT ins;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        lastTaken  = 1'b0;
        pcNow      = 32'h0000_1000;
        for (int r = 0; r < 32; r++) modelRegs[r] = '0;

        for (int i = 0; i < 16; i++) begin      // Outputs quiet in reset
            @(negedge clk);
            checkQuiet("reset");
        end
        @(posedge clk);
        #1;
        arstN = 1'b1;
        repeat (3) driveIdle();                 // Monitor checks quiet outputs
        finishTest("reset");

        for (int i = 0; i < 80; i++) presentInstr(makeInstr({$random(seed)} % 4));
        finishTest("aluUpper");

        for (int i = 0; i < 60; i++) presentInstr(makeInstr(2 + {$random(seed)} % 4));
        finishTest("jumps");

        for (int i = 0; i < 48; i++) begin
            loadReg(5'd1, pickValue());
            loadReg(5'd2, pickValue());
            ins        = makeInstr(6);
            ins[19:15] = 5'd1;
            ins[24:20] = 5'd2;
            presentInstr(ins);
            presentInstr(makeInstr(3));         // Lost if the branch is taken
        end
        finishTest("branches");

        for (int i = 0; i < 30; i++) begin
            presentInstr(makeInstr(4 + {$random(seed)} % 2));
            if (i % 2) driveIdle();             // Gap keeps the next one alive
            presentInstr(makeInstr(3));
            presentInstr(makeInstr(2));
        end
        finishTest("squash");

        for (int i = 0; i < 40; i++) begin
            ins = makeInstr({$random(seed)} % 8);
            if (i % 2 == 0) ins[11:7] = '0;
            if (i % 4 == 1) ins[19:15] = '0;    // Read x0
            presentInstr(ins);
        end
        finishTest("x0Noop");

        for (int i = 0; i < 300; i++) begin
            if ({$random(seed)} % 5 == 0) driveIdle();
            else presentInstr(makeInstr({$random(seed)} % 8));
        end
        finishTest("mixed");

        $display("Tests: %0d, results checked: %0d, slots dropped: %0d, errors: %0d",
                 testsDone, resultCnt, droppedCnt, errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
